//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := modexp_tb
FILELIST  := list.f
BUILD     := obj_dir
SIM       := $(BUILD)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: run clean

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

clean:
	rm -rf $(BUILD)

//--- include/modexp_consts.svh
/* modexp constants
   operand geometry of the word-serial exponentiator */
`ifndef MODEXP_CONSTS_SVH
`define MODEXP_CONSTS_SVH

// bits per operand word
`define WORD_WIDTH 16

// words per operand, a 64-bit modulus
`define NUM_WORDS 4

// exponent bits scanned by the sequencer
`define EXP_BITS (`WORD_WIDTH * `NUM_WORDS)

// width of a word index
`define IDX_WIDTH 2

`endif

//--- list.f
+incdir+include
src/modexp_types_pkg.sv
src/modexp_ctrl_pkg.sv
src/word_mac.sv
src/mont_mul.sv
src/operand_bank.sv
src/modexp_sequencer.sv
src/modexp_top.sv
verification/modexp_props.sv
verification/modexp_tb.sv

//--- src/modexp_ctrl_pkg.sv
/* modexp control types
   sequencer phases and multiplier operand selection */
package modexp_ctrl_pkg;

	typedef enum logic [2:0] {
		IDLE,
		TO_MONT,	// m_bar = MonPro(m, t)
		SCAN,		// skip leading zero bits of e
		SQUARE,
		MULTIPLY,
		FROM_MONT,	// MonPro(1, c_bar)
		DONE
	} exp_phase_t;

	typedef enum logic [1:0] {A_BASE, A_CBAR, A_ONE} a_sel_t;

	typedef enum logic [1:0] {B_T, B_CBAR, B_MBAR} b_sel_t;

endpackage

//--- src/modexp_sequencer.sv
/* exponent sequencer
   left-to-right square and multiply over mont_mul, start and read ports */
`timescale 1ns/1ps
`include "modexp_consts.svh"

module modexp_sequencer (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        start_req,
	output logic                        start_ack,
	input  logic                        read_req,
	output logic                        read_ack,
	output modexp_types_pkg::word_t     res_word,
	input  modexp_types_pkg::word_vec_t base,
	input  modexp_types_pkg::word_vec_t exponent,
	input  modexp_types_pkg::word_vec_t t_mont,
	input  modexp_types_pkg::word_vec_t r_mont,
	input  modexp_types_pkg::word_vec_t product,
	input  logic                        mul_done,
	output logic                        mul_start,
	output modexp_types_pkg::word_vec_t a,
	output modexp_types_pkg::word_vec_t b
);
	localparam modexp_types_pkg::word_idx_t LAST = modexp_types_pkg::word_idx_t'(`NUM_WORDS - 1);
	localparam modexp_types_pkg::bit_idx_t TOP_BIT = modexp_types_pkg::bit_idx_t'(`EXP_BITS - 1);

	modexp_ctrl_pkg::exp_phase_t phase;
	modexp_ctrl_pkg::a_sel_t     a_sel;
	modexp_ctrl_pkg::b_sel_t     b_sel;
	modexp_types_pkg::word_vec_t c_bar;
	modexp_types_pkg::word_vec_t m_bar;
	modexp_types_pkg::bit_idx_t  bit_pos;
	modexp_types_pkg::word_idx_t rd_idx;
	logic [`EXP_BITS-1:0]        exp_flat;
	logic                        exp_bit;
	logic                        last_bit;
	logic                        start_go;

	assign exp_flat = exponent;
	assign exp_bit = exp_flat[bit_pos];
	assign last_bit = (bit_pos == '0);
	assign start_go = (phase == modexp_ctrl_pkg::IDLE) && start_req;

	always_comb begin
		case (phase)
			modexp_ctrl_pkg::TO_MONT: begin
				a_sel = modexp_ctrl_pkg::A_BASE;
				b_sel = modexp_ctrl_pkg::B_T;
			end
			modexp_ctrl_pkg::MULTIPLY: begin
				a_sel = modexp_ctrl_pkg::A_CBAR;
				b_sel = modexp_ctrl_pkg::B_MBAR;
			end
			modexp_ctrl_pkg::FROM_MONT: begin
				a_sel = modexp_ctrl_pkg::A_ONE;
				b_sel = modexp_ctrl_pkg::B_CBAR;
			end
			default: begin	// squaring
				a_sel = modexp_ctrl_pkg::A_CBAR;
				b_sel = modexp_ctrl_pkg::B_CBAR;
			end
		endcase
	end

	always_comb begin
		case (a_sel)
			modexp_ctrl_pkg::A_BASE: a = base;
			modexp_ctrl_pkg::A_ONE:  a = modexp_types_pkg::word_vec_t'(1);
			default:                 a = c_bar;
		endcase
		case (b_sel)
			modexp_ctrl_pkg::B_T:    b = t_mont;
			modexp_ctrl_pkg::B_MBAR: b = m_bar;
			default:                 b = c_bar;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			phase <= modexp_ctrl_pkg::IDLE;
			bit_pos <= TOP_BIT;
			mul_start <= 1'b0;
			start_ack <= 1'b0;
		end else begin
			mul_start <= 1'b0;
			case (phase)
				modexp_ctrl_pkg::IDLE: if (start_req) begin
					phase <= modexp_ctrl_pkg::TO_MONT;
					bit_pos <= TOP_BIT;
					mul_start <= 1'b1;
				end
				modexp_ctrl_pkg::TO_MONT: if (mul_done) phase <= modexp_ctrl_pkg::SCAN;
				modexp_ctrl_pkg::SCAN: begin	// one bit per cycle until the leading 1
					if (exp_bit) begin
						phase <= modexp_ctrl_pkg::SQUARE;
						mul_start <= 1'b1;
					end else if (last_bit) begin
						phase <= modexp_ctrl_pkg::FROM_MONT;	// e == 0 gives 1
						mul_start <= 1'b1;
					end else begin
						bit_pos <= bit_pos - 1'b1;
					end
				end
				modexp_ctrl_pkg::SQUARE: if (mul_done) begin
					mul_start <= 1'b1;
					if (exp_bit) phase <= modexp_ctrl_pkg::MULTIPLY;
					else if (last_bit) phase <= modexp_ctrl_pkg::FROM_MONT;
					else bit_pos <= bit_pos - 1'b1;
				end
				modexp_ctrl_pkg::MULTIPLY: if (mul_done) begin
					mul_start <= 1'b1;
					if (last_bit) begin
						phase <= modexp_ctrl_pkg::FROM_MONT;
					end else begin
						bit_pos <= bit_pos - 1'b1;
						phase <= modexp_ctrl_pkg::SQUARE;
					end
				end
				modexp_ctrl_pkg::FROM_MONT: if (mul_done) begin
					phase <= modexp_ctrl_pkg::DONE;
					start_ack <= 1'b1;	// result now sits in c_bar
				end
				default: if (!start_req) begin
					start_ack <= 1'b0;
					phase <= modexp_ctrl_pkg::IDLE;
				end
			endcase
		end
	end

	// c_bar starts as Montgomery one and takes every later product
	always_ff @(posedge clk) begin
		if (start_go) c_bar <= r_mont;
		else if (mul_done && phase != modexp_ctrl_pkg::TO_MONT) c_bar <= product;
		if (mul_done && phase == modexp_ctrl_pkg::TO_MONT) m_bar <= product;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			read_ack <= 1'b0;
			rd_idx <= '0;
			res_word <= '0;
		end else begin
			read_ack <= read_req;
			if (read_req && !read_ack) res_word <= c_bar[rd_idx];
			if (read_ack && !read_req) rd_idx <= (rd_idx == LAST) ? '0 : rd_idx + 1'b1;
		end
	end

endmodule

//--- src/modexp_top.sv
/* modular exponentiator top
   operand bank, exponent sequencer and Montgomery multiplier */
`timescale 1ns/1ps

module modexp_top (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    load_req,
	output logic                    load_ack,
	input  modexp_types_pkg::word_t m_word,
	input  modexp_types_pkg::word_t e_word,
	input  modexp_types_pkg::word_t n_word,
	input  modexp_types_pkg::word_t r_word,
	input  modexp_types_pkg::word_t t_word,
	input  modexp_types_pkg::word_t nprime0,
	input  logic                    start_req,
	output logic                    start_ack,
	input  logic                    read_req,
	output logic                    read_ack,
	output modexp_types_pkg::word_t res_word
);
	modexp_types_pkg::word_vec_t base, exponent, modulus, r_mont, t_mont;
	modexp_types_pkg::word_vec_t a, b, product;
	modexp_types_pkg::word_t     nprime0_q;
	logic                        mul_start, mul_done;

	operand_bank u_bank (
		.clk(clk), .reset(reset), .load_req(load_req), .load_ack(load_ack),
		.m_word(m_word), .e_word(e_word), .n_word(n_word), .r_word(r_word),
		.t_word(t_word), .nprime0(nprime0), .base(base), .exponent(exponent),
		.modulus(modulus), .r_mont(r_mont), .t_mont(t_mont), .nprime0_q(nprime0_q)
	);

	modexp_sequencer u_seq (
		.clk(clk), .reset(reset), .start_req(start_req), .start_ack(start_ack),
		.read_req(read_req), .read_ack(read_ack), .res_word(res_word),
		.base(base), .exponent(exponent), .t_mont(t_mont), .r_mont(r_mont),
		.product(product), .mul_done(mul_done), .mul_start(mul_start), .a(a), .b(b)
	);

	mont_mul u_mul (
		.clk(clk), .reset(reset), .mul_start(mul_start), .a(a), .b(b),
		.n(modulus), .nprime0(nprime0_q), .product(product), .mul_done(mul_done)
	);

endmodule

//--- src/modexp_types_pkg.sv
/* modexp data types
   words, whole operands and their indexes */
`include "modexp_consts.svh"

package modexp_types_pkg;

	// one operand word
	typedef logic [`WORD_WIDTH-1:0] word_t;

	// whole operand, word 0 is least significant
	typedef logic [`NUM_WORDS-1:0][`WORD_WIDTH-1:0] word_vec_t;

	// word position inside an operand
	typedef logic [`IDX_WIDTH-1:0] word_idx_t;

	// exponent bit position
	typedef logic [$clog2(`EXP_BITS)-1:0] bit_idx_t;

endpackage

//--- src/mont_mul.sv
/* Montgomery product a * b * R^-1 mod n, CIOS form
   sequenced word by word through one word_mac, two cycles per step */
`timescale 1ns/1ps
`include "modexp_consts.svh"

module mont_mul (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        mul_start,
	input  modexp_types_pkg::word_vec_t a,
	input  modexp_types_pkg::word_vec_t b,
	input  modexp_types_pkg::word_vec_t n,
	input  modexp_types_pkg::word_t     nprime0,
	output modexp_types_pkg::word_vec_t product,
	output logic                        mul_done
);
	typedef enum logic [2:0] {
		MM_IDLE, MM_MUL_B, MM_FOLD_TOP, MM_RED, MM_ADD_N, MM_FOLD_C, MM_FOLD_HI
	} mm_step_t;

	localparam int TOP = `NUM_WORDS;
	localparam modexp_types_pkg::word_idx_t LAST = modexp_types_pkg::word_idx_t'(`NUM_WORDS - 1);

	mm_step_t                   step;
	logic                       store;	// second cycle of a MAC step
	modexp_types_pkg::word_t    acc [TOP+2];	// two words above the operand
	modexp_types_pkg::word_t    c_q;	// running carry
	modexp_types_pkg::word_t    m_q;	// reduction factor
	modexp_types_pkg::word_idx_t i;
	modexp_types_pkg::word_idx_t j;
	modexp_types_pkg::word_t    x, y, z, carry_in;
	modexp_types_pkg::word_t    sum, carry;

	word_mac u_mac (
		.clk(clk), .reset(reset), .x(x), .y(y), .z(z), .carry_in(carry_in),
		.sum(sum), .carry(carry)
	);

	// operands of the step being issued
	always_comb begin
		x = '0;
		y = '0;
		z = '0;
		carry_in = '0;
		case (step)
			MM_MUL_B: begin
				x = a[i];
				y = b[j];
				z = acc[j];
				carry_in = (j == '0) ? '0 : c_q;	// carry restarts per outer word
			end
			MM_FOLD_TOP: begin
				z = acc[TOP];
				carry_in = c_q;
			end
			MM_RED: begin
				x = acc[0];
				y = nprime0;
			end
			MM_ADD_N: begin
				x = m_q;
				y = n[j];
				z = acc[j];
				carry_in = (j == '0) ? '0 : c_q;
			end
			MM_FOLD_C: begin
				z = acc[TOP];
				carry_in = c_q;
			end
			MM_FOLD_HI: begin
				z = acc[TOP+1];
				carry_in = c_q;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			step <= MM_IDLE;
			store <= 1'b0;
			i <= '0;
			j <= '0;
			c_q <= '0;
			m_q <= '0;
			mul_done <= 1'b0;
			product <= '0;
			for (int w = 0; w < TOP + 2; w++) begin
				acc[w] <= '0;
			end
		end else begin
			mul_done <= 1'b0;
			if (step == MM_IDLE) begin
				if (mul_start) begin
					step <= MM_MUL_B;
					i <= '0;
					j <= '0;
				end
			end else if (!store) begin
				store <= 1'b1;	// result of the issue lands next cycle
			end else begin
				store <= 1'b0;
				case (step)
					MM_MUL_B: begin
						acc[j] <= sum;
						c_q <= carry;
						j <= (j == LAST) ? '0 : j + 1'b1;
						if (j == LAST) step <= MM_FOLD_TOP;
					end
					MM_FOLD_TOP: begin
						acc[TOP] <= sum;
						acc[TOP+1] <= carry;
						step <= MM_RED;
					end
					MM_RED: begin
						m_q <= sum;	// low word only, mod 2^w
						step <= MM_ADD_N;
					end
					MM_ADD_N: begin
						if (j != '0) acc[j-1] <= sum;	// shifted down one word
						c_q <= carry;
						j <= (j == LAST) ? '0 : j + 1'b1;
						if (j == LAST) step <= MM_FOLD_C;
					end
					MM_FOLD_C: begin
						acc[TOP-1] <= sum;
						c_q <= carry;
						step <= MM_FOLD_HI;
					end
					MM_FOLD_HI: begin
						if (i == LAST) begin
							for (int w = 0; w < TOP; w++) begin
								product[w] <= acc[w];
							end
							for (int w = 0; w < TOP + 2; w++) begin
								acc[w] <= '0;
							end
							c_q <= '0;
							mul_done <= 1'b1;
							step <= MM_IDLE;
						end else begin
							acc[TOP] <= sum;
							i <= i + 1'b1;
							step <= MM_MUL_B;
						end
					end
					default: step <= MM_IDLE;
				endcase
			end
		end
	end

endmodule

//--- src/operand_bank.sv
/* operand bank
   four-phase load port filling m, e, n, r, t and holding nprime0 */
`timescale 1ns/1ps
`include "modexp_consts.svh"

module operand_bank (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        load_req,
	output logic                        load_ack,
	input  modexp_types_pkg::word_t     m_word,
	input  modexp_types_pkg::word_t     e_word,
	input  modexp_types_pkg::word_t     n_word,
	input  modexp_types_pkg::word_t     r_word,
	input  modexp_types_pkg::word_t     t_word,
	input  modexp_types_pkg::word_t     nprime0,
	output modexp_types_pkg::word_vec_t base,
	output modexp_types_pkg::word_vec_t exponent,
	output modexp_types_pkg::word_vec_t modulus,
	output modexp_types_pkg::word_vec_t r_mont,
	output modexp_types_pkg::word_vec_t t_mont,
	output modexp_types_pkg::word_t     nprime0_q
);
	localparam modexp_types_pkg::word_idx_t LAST = modexp_types_pkg::word_idx_t'(`NUM_WORDS - 1);

	modexp_types_pkg::word_idx_t wr_idx;
	logic                        wr_en;

	assign wr_en = load_req && !load_ack;	// req seen, ack not yet up

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			load_ack <= 1'b0;
			wr_idx <= '0;
		end else begin
			load_ack <= load_req;
			if (load_ack && !load_req) wr_idx <= (wr_idx == LAST) ? '0 : wr_idx + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			base[wr_idx] <= m_word;
			exponent[wr_idx] <= e_word;
			modulus[wr_idx] <= n_word;
			r_mont[wr_idx] <= r_word;
			t_mont[wr_idx] <= t_word;
			if (wr_idx == '0) nprime0_q <= nprime0;	// one word constant
		end
	end

endmodule

//--- src/word_mac.sv
/* word multiply-accumulate
   registers x * y + z + carry_in as a carry word and a sum word */
`timescale 1ns/1ps
`include "modexp_consts.svh"

module word_mac (
	input  logic                     clk,
	input  logic                     reset,
	input  modexp_types_pkg::word_t  x,
	input  modexp_types_pkg::word_t  y,
	input  modexp_types_pkg::word_t  z,
	input  modexp_types_pkg::word_t  carry_in,
	output modexp_types_pkg::word_t  sum,
	output modexp_types_pkg::word_t  carry
);
	logic [2*`WORD_WIDTH-1:0] full;	// never overflows two words

	assign full = x * y + z + carry_in;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			{carry, sum} <= '0;
		end else begin
			{carry, sum} <= full;
		end
	end

endmodule

//--- verification/modexp_props.sv
/* handshake properties
   four-phase req/ack ordering on the load, start and read ports */
`timescale 1ns/1ps

module modexp_props (
	input logic clk,
	input logic reset,
	input logic load_req,
	input logic load_ack,
	input logic start_req,
	input logic start_ack,
	input logic read_req,
	input logic read_ack
);
	// an ack may only rise after its req was seen high
	assert property (@(posedge clk) disable iff (reset) $rose(load_ack) |-> $past(load_req))
		else $error("load_ack rose while load_req was low");
	assert property (@(posedge clk) disable iff (reset) $rose(start_ack) |-> $past(start_req))
		else $error("start_ack rose while start_req was low");
	assert property (@(posedge clk) disable iff (reset) $rose(read_ack) |-> $past(read_req))
		else $error("read_ack rose while read_req was low");

	// and may only fall once its req was seen low
	assert property (@(posedge clk) disable iff (reset) $fell(load_ack) |-> !$past(load_req))
		else $error("load_ack fell while load_req was high");
	assert property (@(posedge clk) disable iff (reset) $fell(start_ack) |-> !$past(start_req))
		else $error("start_ack fell while start_req was high");
	assert property (@(posedge clk) disable iff (reset) $fell(read_ack) |-> !$past(read_req))
		else $error("read_ack fell while read_req was high");

endmodule

bind modexp_top modexp_props u_props (
	.clk(clk), .reset(reset),
	.load_req(load_req), .load_ack(load_ack),
	.start_req(start_req), .start_ack(start_ack),
	.read_req(read_req), .read_ack(read_ack)
);

//--- verification/modexp_tb.sv
/* modexp testbench
   random operands from an LFSR, checked against a wide-arithmetic model */
`timescale 1ns/1ps
`include "modexp_consts.svh"

module modexp_tb;
	localparam int OP = `WORD_WIDTH * `NUM_WORDS;	// operand bits
	localparam int W = `WORD_WIDTH;
	localparam int NUM_RANDOM = 20;
	localparam int NUM_TESTS = NUM_RANDOM + 2;
	localparam int LIMIT = NUM_TESTS * (2 * `EXP_BITS + 2) * 96 + NUM_TESTS * 2000;

	logic clk, reset;
	logic load_req, load_ack, start_req, start_ack, read_req, read_ack;
	logic [W-1:0] m_word, e_word, n_word, r_word, t_word, nprime0, res_word;
	logic [31:0] lfsr;
	logic [OP-1:0] m, e, n;

	modexp_top DUT (
		.clk(clk), .reset(reset), .load_req(load_req), .load_ack(load_ack),
		.m_word(m_word), .e_word(e_word), .n_word(n_word), .r_word(r_word),
		.t_word(t_word), .nprime0(nprime0), .start_req(start_req), .start_ack(start_ack),
		.read_req(read_req), .read_ack(read_ack), .res_word(res_word)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);	// x^32+x^22+x^2+x+1
	endfunction

	task automatic rand_operand(output logic [OP-1:0] v);
		for (int k = 0; k < OP; k++) begin
			v[k] = lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// 0 to 5 falling edges before a req drop
	task automatic random_delay();
		logic [2:0] d;
		for (int k = 0; k < 3; k++) begin
			d[k] = lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
		repeat (int'(d) % 6) @(negedge clk);
	endtask

	task automatic check_value(input string name, input logic [OP-1:0] got,
			input logic [OP-1:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
			$display(">>> FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	function automatic logic [OP-1:0] mod_mul(input logic [OP-1:0] a, b, nn);
		logic [2*OP-1:0] p;
		p = {{OP{1'b0}}, a} * {{OP{1'b0}}, b};
		return OP'(p % {{OP{1'b0}}, nn});
	endfunction

	// left-to-right square and multiply
	function automatic logic [OP-1:0] mod_exp(input logic [OP-1:0] mm, ee, nn);
		logic [OP-1:0] acc;
		acc = OP'(1) % nn;
		for (int i = OP - 1; i >= 0; i--) begin
			acc = mod_mul(acc, acc, nn);
			if (ee[i]) acc = mod_mul(acc, mm, nn);
		end
		return acc;
	endfunction

	// -n^-1 mod 2^W, each Newton step doubles the correct low bits
	function automatic logic [W-1:0] neg_inverse(input logic [W-1:0] n0);
		logic [W-1:0] inv;
		inv = n0;
		repeat (4) inv = inv * (W'(2) - n0 * inv);
		return W'(0) - inv;
	endfunction

	task automatic load_operands(input logic [OP-1:0] r, t, input logic [W-1:0] np0);
		for (int w = 0; w < `NUM_WORDS; w++) begin
			m_word = m[w*W +: W];
			e_word = e[w*W +: W];
			n_word = n[w*W +: W];
			r_word = r[w*W +: W];
			t_word = t[w*W +: W];
			nprime0 = np0;
			load_req = 1'b1;
			do @(negedge clk); while (!load_ack);
			random_delay();
			load_req = 1'b0;
			do @(negedge clk); while (load_ack);
		end
	endtask

	task automatic run_exponent();
		start_req = 1'b1;
		do @(negedge clk); while (!start_ack);	// latency depends on e
		random_delay();
		start_req = 1'b0;
		do @(negedge clk); while (start_ack);
	endtask

	task automatic read_result(output logic [OP-1:0] v);
		for (int w = 0; w < `NUM_WORDS; w++) begin
			read_req = 1'b1;
			do @(negedge clk); while (!read_ack);
			v[w*W +: W] = res_word;
			random_delay();
			read_req = 1'b0;
			do @(negedge clk); while (read_ack);
		end
	endtask

	task automatic run_test(input logic second_pass);
		logic [2*OP-1:0] big_r;
		logic [OP-1:0] r, t, expected, got, again;
		big_r = {{(OP-1){1'b0}}, 1'b1, {OP{1'b0}}};	// R = 2^OP
		r = OP'(big_r % {{OP{1'b0}}, n});
		t = mod_mul(r, r, n);
		expected = mod_exp(m, e, n);
		load_operands(r, t, neg_inverse(n[W-1:0]));
		run_exponent();
		read_result(got);
		check_value("result mod n", got % n, expected);	// DUT result may sit in [n, 2n)
		if (second_pass) begin
			read_result(again);
			check_value("second read", again, got);
		end
	endtask

	// n odd and below R/4 so unreduced products stay inside the operand
	task automatic random_operands();
		rand_operand(n);
		n[OP-1 -: 3] = 3'b001;
		n[0] = 1'b1;
		rand_operand(m);
		m = m % n;
		rand_operand(e);
	endtask

	initial begin
		repeat (LIMIT) @(posedge clk);
		$display("the run timed out before all tests finished");
		$display(">>> FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		load_req = 1'b0;
		start_req = 1'b0;
		read_req = 1'b0;
		m_word = '0;
		e_word = '0;
		n_word = '0;
		r_word = '0;
		t_word = '0;
		nprime0 = '0;
		lfsr = 32'hdc36_fbfa;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_value("load_ack", OP'(load_ack), '0);
		check_value("start_ack", OP'(start_ack), '0);
		check_value("read_ack", OP'(read_ack), '0);
		check_value("res_word", OP'(res_word), '0);
		for (int k = 0; k < NUM_RANDOM; k++) begin
			random_operands();
			run_test(1'b1);
		end
		random_operands();
		e = '0;	// gives 1
		run_test(1'b0);
		random_operands();
		e = OP'(1);	// gives m mod n
		run_test(1'b0);
		$display(">>> PASS");
		$finish;
	end

endmodule
